// File: bench/bp_ref.svh
`ifndef BP_REF_SVH
`define BP_REF_SVH

typedef struct packed {
  logic branch;
  pc_t baddr;
  logic ret;
  pc_t raddr;
  logic miss;
  pc_t maddr;
} expect_t;

btb_tag_t ref_tag [btb_entries];
pc_t ref_target [btb_entries];
int ref_count [bht_entries]; // Counter value 0 to 3
bht_index_t ref_history;
pc_t ref_stack [$];          // Newest return address at the back

function automatic void ref_reset();
  for (int i = 0; i < btb_entries; i++) begin
    ref_tag[i] = '0;
    ref_target[i] = '0;
  end
  for (int i = 0; i < bht_entries; i++) begin
    ref_count[i] = 0;
  end
  ref_history = '0;
  ref_stack.delete();
endfunction

// Predicts from the inputs now on the DUT and then learns from the update
function automatic expect_t ref_step();
  expect_t e;
  btb_index_t slot;
  bht_index_t uidx;
  logic hit;
  logic popped;
  e = '0;
  slot = get_pc[6:1];
  hit = (ref_tag[slot] == get_pc[31:7]);
  if (!clear && get_uncond) begin
    e.branch = hit;
  end else if (!clear && get_branch) begin
    e.branch = hit && (ref_count[ref_history ^ get_pc[8:1]] >= 2);
  end
  e.baddr = e.branch ? ref_target[slot] : '0;
  popped = get_return && !clear && (ref_stack.size() > 0);
  e.ret = popped;
  e.raddr = popped ? ref_stack[$] : '0;
  e.miss = upd_branch && (upd_jump != upd_pred);
  if (upd_branch && upd_jump) begin
    e.maddr = upd_addr;
  end else if (upd_branch) begin
    e.maddr = upd_npc;
  end

  if (upd_branch) begin
    uidx = ref_history ^ upd_pc[8:1];
    if (upd_jump && ref_count[uidx] < 3) begin
      ref_count[uidx]++;
    end else if (!upd_jump && ref_count[uidx] > 0) begin
      ref_count[uidx]--;
    end
    ref_history = {ref_history[6:0], upd_jump};
  end
  if (upd_uncond || (upd_branch && upd_jump)) begin
    ref_tag[upd_pc[6:1]] = upd_pc[31:7];
    ref_target[upd_pc[6:1]] = upd_addr;
  end
  if (popped) begin
    void'(ref_stack.pop_back());
  end
  if (upd_return) begin
    ref_stack.push_back(upd_npc);
    if (ref_stack.size() > ras_entries) begin
      void'(ref_stack.pop_front()); // Oldest entry is lost
    end
  end
  return e;
endfunction

`endif

// File: bench/bp_tb.sv
module bp_tb
  import bp_config_pkg::*;
  import bp_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int stream_len = 500;
  localparam int test_cycles = 2 * stream_len + 1000; // Two random streams plus directed tests
  localparam int cycle_limit = 2 * test_cycles;
  localparam int q_branch = 0;
  localparam int q_uncond = 1;
  localparam int q_return = 2;

  logic clock;
  logic reset;
  logic clear;
  pc_t get_pc;
  logic get_branch;
  logic get_uncond;
  logic get_return;
  pc_t upd_pc;
  pc_t upd_addr;
  pc_t upd_npc;
  logic upd_branch;
  logic upd_jump;
  logic upd_uncond;
  logic upd_return;
  logic upd_pred;
  logic pred_branch;
  pc_t pred_baddr;
  logic pred_return;
  pc_t pred_raddr;
  logic pred_miss;
  pc_t pred_maddr;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  pc_t branch_pcs [4] = '{32'h8000_0010, 32'h8000_0044, 32'h8000_0180, 32'h9000_0010};

  `include "bp_ref.svh"

  bp_top dut0 (.*);

  initial clock = 1'b0;
  always #10 clock = ~clock;

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic idle_inputs();
    clear = 1'b0;
    get_pc = '0;
    get_branch = 1'b0;
    get_uncond = 1'b0;
    get_return = 1'b0;
    upd_pc = '0;
    upd_addr = '0;
    upd_npc = '0;
    upd_branch = 1'b0;
    upd_jump = 1'b0;
    upd_uncond = 1'b0;
    upd_return = 1'b0;
    upd_pred = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
    idle_inputs();
  endtask

  task automatic set_query(input pc_t pc, input int kind);
    get_pc = pc;
    get_branch = (kind == q_branch);
    get_uncond = (kind == q_uncond);
    get_return = (kind == q_return);
  endtask

  task automatic set_branch_update(input pc_t pc, input pc_t target, input logic taken,
                                   input logic pred);
    upd_branch = 1'b1;
    upd_pc = pc;
    upd_addr = target;
    upd_npc = pc + 32'd4;
    upd_jump = taken;
    upd_pred = pred;
  endtask

  task automatic set_jump_update(input pc_t pc, input pc_t target);
    upd_uncond = 1'b1;
    upd_jump = 1'b1;
    upd_pc = pc;
    upd_addr = target;
  endtask

  task automatic set_return_push(input pc_t npc);
    upd_return = 1'b1;
    upd_npc = npc;
  endtask

  task automatic finish_test(input string name, input int first_error);
    @(negedge clock);
    #1;
    $display("test %s finished with %0d mismatches", name, errors - first_error);
  endtask

  // Outputs are settled half a cycle after the inputs change
  always @(negedge clock) begin
    expect_t e;
    if (reset) begin
      e = ref_step();
      check_bit("pred_branch", pred_branch, e.branch);
      check_pc("pred_baddr", pred_baddr, e.baddr);
      check_bit("pred_return", pred_return, e.ret);
      check_pc("pred_raddr", pred_raddr, e.raddr);
      check_bit("pred_miss", pred_miss, e.miss);
      check_pc("pred_maddr", pred_maddr, e.maddr);
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int first;
    pc_t pc;
    void'($urandom(32'h9015d148));
    reset = 1'b0;
    idle_inputs();
    ref_reset();
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b1;

    first = errors;
    for (int k = 0; k < 3; k++) begin
      next_cycle();
      set_query(32'h8000_0100 + 4 * k, k);
    end
    finish_test("reset", first);

    first = errors;
    next_cycle();
    set_jump_update(32'h8000_0124, 32'h8000_0400);
    next_cycle();
    set_query(32'h8000_0124, q_uncond);
    next_cycle();
    set_query(32'h8000_0124 + 32'h0001_0000, q_uncond); // Same index but another tag
    finish_test("btb", first);

    first = errors;
    repeat (14) begin // History fills with ones and one counter then saturates
      next_cycle();
      set_branch_update(branch_pcs[0], branch_pcs[0] + 32'h100, 1'b1, 1'b0);
      set_query(branch_pcs[0], q_branch);
    end
    for (int n = 0; n < stream_len; n++) begin
      next_cycle();
      set_query(branch_pcs[$urandom_range(3, 0)], $urandom_range(1, 0));
      if ($urandom_range(1, 0)) begin
        pc = branch_pcs[$urandom_range(3, 0)];
        set_branch_update(pc, pc + 32'h100, $urandom_range(1, 0), 1'b0);
      end
    end
    finish_test("gshare", first);

    first = errors;
    for (int k = 0; k < 3; k++) begin
      next_cycle();
      set_return_push(32'h8000_0800 + 4 * k);
    end
    repeat (4) begin // Last pop finds the stack empty
      next_cycle();
      set_query(32'h8000_0300, q_return);
    end
    for (int k = 0; k < 9; k++) begin
      next_cycle();
      set_return_push(32'h8000_1000 + 4 * k);
    end
    repeat (9) begin
      next_cycle();
      set_query(32'h8000_0300, q_return);
    end
    next_cycle();
    set_return_push(32'h8000_2000);
    next_cycle();
    set_return_push(32'h8000_2004);
    next_cycle();
    set_query(32'h8000_0300, q_return);
    set_return_push(32'h8000_2008); // Replaces the popped top
    repeat (3) begin
      next_cycle();
      set_query(32'h8000_0300, q_return);
    end
    finish_test("return stack", first);

    first = errors;
    for (int n = 0; n < stream_len; n++) begin
      next_cycle();
      set_branch_update($urandom() & 32'hffff_fffe, $urandom(), $urandom_range(1, 0),
                        $urandom_range(1, 0));
      upd_branch = $urandom_range(1, 0);
    end
    finish_test("miss report", first);

    first = errors;
    next_cycle();
    set_jump_update(32'h8000_0520, 32'h8000_0a00);
    set_return_push(32'h8000_3000);
    next_cycle();
    clear = 1'b1;
    set_query(32'h8000_0520, q_uncond);
    next_cycle();
    clear = 1'b1;
    set_query(32'h8000_0300, q_return);
    next_cycle();
    clear = 1'b1;
    set_jump_update(32'h8000_0540, 32'h8000_0b00);
    set_return_push(32'h8000_3004);
    next_cycle();
    set_query(32'h8000_0540, q_uncond);
    next_cycle();
    set_query(32'h8000_0520, q_uncond);
    repeat (3) begin
      next_cycle();
      set_query(32'h8000_0300, q_return);
    end
    finish_test("clear", first);

    next_cycle();
    @(negedge clock);
    #1;
    $display("%0d checks, %0d mismatches", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+bench
source/bp_config_pkg.sv
source/bp_types_pkg.sv
source/bp_table_if.sv
source/btb.sv
source/bht.sv
source/ras.sv
source/bp_ctrl.sv
source/bp_top.sv
bench/bp_tb.sv

// File: source/bht.sv
module bht
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input logic clock,
  input logic reset,
  bht_if.tbl bus
);

  sat_t counters [bht_entries];

  // Fetch lookup port
  assign bus.get_sat = counters[bus.get_index];

  // Update port read in the same cycle as its write back
  assign bus.upd_sat = counters[bus.upd_index];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_entries; i++) begin
        counters[i] <= '0; // Strongly not taken
      end
    end else if (bus.wen) begin
      counters[bus.waddr] <= bus.wdata;
    end
  end

endmodule

// File: source/bp_config_pkg.sv
package bp_config_pkg;

  localparam int pc_width = 32;

  localparam int btb_entries = 64;
  localparam int bht_entries = 256;
  localparam int ras_entries = 8;

  localparam int btb_index_width = $clog2(btb_entries);
  localparam int bht_index_width = $clog2(bht_entries);
  localparam int ras_index_width = $clog2(ras_entries);

  // Bit 0 of the PC is never used, so the tag starts above the index
  localparam int btb_tag_width = pc_width - btb_index_width - 1;

endpackage

// File: source/bp_ctrl.sv
module bp_ctrl
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input pc_t get_pc,
  input logic get_branch,
  input logic get_uncond,
  input logic get_return,
  input pc_t upd_pc,
  input pc_t upd_addr,
  input pc_t upd_npc,
  input logic upd_branch,
  input logic upd_jump,
  input logic upd_uncond,
  input logic upd_return,
  input logic upd_pred,
  output logic pred_branch,
  output pc_t pred_baddr,
  output logic pred_return,
  output pc_t pred_raddr,
  output logic pred_miss,
  output pc_t pred_maddr,
  btb_if.ctrl btb_bus,
  bht_if.ctrl bht_bus,
  ras_if.ctrl ras_bus
);

  bht_index_t history; // Global outcome history, newest at bit 0
  btb_tag_t get_tag;
  btb_tag_t upd_tag;
  logic btb_hit;
  sat_t next_sat;
  logic ras_take;

  assign get_tag = get_pc[pc_width-1:btb_index_width+1];
  assign upd_tag = upd_pc[pc_width-1:btb_index_width+1];

  // Target lookup
  assign btb_bus.raddr = get_pc[btb_index_width:1];
  assign btb_hit = (btb_bus.rdata[pc_width +: btb_tag_width] == get_tag);

  // Gshare hashing for lookup and update
  assign bht_bus.get_index = history ^ get_pc[bht_index_width:1];
  assign bht_bus.upd_index = history ^ upd_pc[bht_index_width:1];

  always_comb begin
    pred_branch = 1'b0;
    if (!clear) begin
      if (get_uncond) begin
        pred_branch = btb_hit;
      end else if (get_branch) begin
        pred_branch = btb_hit & bht_bus.get_sat[1];
      end
    end
  end

  assign pred_baddr = pred_branch ? btb_bus.rdata[pc_width-1:0] : '0;

  // Saturating counter step
  always_comb begin
    next_sat = bht_bus.upd_sat;
    if (upd_jump && bht_bus.upd_sat != 2'd3) begin
      next_sat = bht_bus.upd_sat + 1'b1;
    end else if (!upd_jump && bht_bus.upd_sat != 2'd0) begin
      next_sat = bht_bus.upd_sat - 1'b1;
    end
  end

  assign bht_bus.wen = upd_branch;
  assign bht_bus.waddr = bht_bus.upd_index;
  assign bht_bus.wdata = next_sat;

  // Only taken branches and jumps are worth a BTB entry
  assign btb_bus.wen = upd_uncond | (upd_branch & upd_jump);
  assign btb_bus.waddr = upd_pc[btb_index_width:1];
  assign btb_bus.wdata = {upd_tag, upd_addr};

  always_ff @(posedge clock) begin
    if (!reset) begin
      history <= '0;
    end else if (upd_branch) begin
      history <= {history[bht_index_width-2:0], upd_jump};
    end
  end

  // Return stack, popped only when a prediction is actually made
  assign ras_take = get_return & ras_bus.valid & ~clear;
  assign ras_bus.pop = ras_take;
  assign ras_bus.push = upd_return;
  assign ras_bus.push_addr = upd_npc;
  assign pred_return = ras_take;
  assign pred_raddr = ras_take ? ras_bus.top : '0;

  // Miss report compares the resolved outcome with what fetch predicted
  assign pred_miss = upd_branch & (upd_jump ^ upd_pred);
  assign pred_maddr = !upd_branch ? '0 : (upd_jump ? upd_addr : upd_npc);

endmodule

// File: source/bp_table_if.sv
interface btb_if import bp_types_pkg::*; ();

  btb_index_t raddr;
  logic wen;
  btb_index_t waddr;
  btb_entry_t wdata;
  btb_entry_t rdata; // Combinational read of raddr

  modport ctrl (output raddr, output wen, output waddr, output wdata, input rdata);
  modport tbl (input raddr, input wen, input waddr, input wdata, output rdata);

endinterface

interface bht_if import bp_types_pkg::*; ();

  bht_index_t get_index; // Fetch lookup
  bht_index_t upd_index; // Update read-modify-write
  logic wen;
  bht_index_t waddr;
  sat_t wdata;
  sat_t get_sat;
  sat_t upd_sat;

  modport ctrl (
    output get_index, output upd_index, output wen, output waddr, output wdata,
    input get_sat, input upd_sat
  );
  modport tbl (
    input get_index, input upd_index, input wen, input waddr, input wdata,
    output get_sat, output upd_sat
  );

endinterface

interface ras_if import bp_types_pkg::*; ();

  logic push;
  pc_t push_addr;
  logic pop;
  pc_t top;    // Newest entry
  logic valid; // Stack not empty

  modport ctrl (output push, output push_addr, output pop, input top, input valid);
  modport stack (input push, input push_addr, input pop, output top, output valid);

endinterface

// File: source/bp_top.sv
module bp_top
  import bp_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input pc_t get_pc,
  input logic get_branch,
  input logic get_uncond,
  input logic get_return,
  input pc_t upd_pc,
  input pc_t upd_addr,
  input pc_t upd_npc,
  input logic upd_branch,
  input logic upd_jump,
  input logic upd_uncond,
  input logic upd_return,
  input logic upd_pred,
  output logic pred_branch,
  output pc_t pred_baddr,
  output logic pred_return,
  output pc_t pred_raddr,
  output logic pred_miss,
  output pc_t pred_maddr
);

  btb_if btb_bus ();
  bht_if bht_bus ();
  ras_if ras_bus ();

  btb btb0 (
    .clock (clock),
    .reset (reset),
    .bus   (btb_bus.tbl)
  );

  bht bht0 (
    .clock (clock),
    .reset (reset),
    .bus   (bht_bus.tbl)
  );

  ras ras0 (
    .clock (clock),
    .reset (reset),
    .bus   (ras_bus.stack)
  );

  bp_ctrl ctrl0 (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .get_pc      (get_pc),
    .get_branch  (get_branch),
    .get_uncond  (get_uncond),
    .get_return  (get_return),
    .upd_pc      (upd_pc),
    .upd_addr    (upd_addr),
    .upd_npc     (upd_npc),
    .upd_branch  (upd_branch),
    .upd_jump    (upd_jump),
    .upd_uncond  (upd_uncond),
    .upd_return  (upd_return),
    .upd_pred    (upd_pred),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_return (pred_return),
    .pred_raddr  (pred_raddr),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr),
    .btb_bus     (btb_bus.ctrl),
    .bht_bus     (bht_bus.ctrl),
    .ras_bus     (ras_bus.ctrl)
  );

endmodule

// File: source/bp_types_pkg.sv
package bp_types_pkg;

  import bp_config_pkg::*;

  // Fetch and target addresses
  typedef logic [pc_width-1:0] pc_t;

  // BTB index is PC bits 6 to 1 and the tag is PC bits 31 to 7
  typedef logic [btb_index_width-1:0] btb_index_t;
  typedef logic [btb_tag_width-1:0] btb_tag_t;

  // Tag in the upper bits and target in the lower bits
  typedef logic [btb_tag_width+pc_width-1:0] btb_entry_t;

  // Gshare index into the counter table
  typedef logic [bht_index_width-1:0] bht_index_t;

  // Bit 1 set means predict taken
  typedef logic [1:0] sat_t;

  typedef logic [ras_index_width-1:0] ras_index_t;

  // One bit wider than the index so a full stack can be counted
  typedef logic [ras_index_width:0] ras_count_t;

endpackage

// File: source/btb.sv
module btb
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input logic clock,
  input logic reset,
  btb_if.tbl bus
);

  btb_entry_t entries [btb_entries];

  assign bus.rdata = entries[bus.raddr];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < btb_entries; i++) begin
        entries[i] <= '0;
      end
    end else if (bus.wen) begin
      entries[bus.waddr] <= bus.wdata;
    end
  end

endmodule

// File: source/ras.sv
module ras
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input logic clock,
  input logic reset,
  ras_if.stack bus
);

  pc_t slots [ras_entries];
  ras_index_t wptr;    // Next free slot
  ras_index_t top_ptr;
  ras_count_t count;
  logic do_pop;

  assign top_ptr = wptr - 1'b1; // Wraps modulo the stack size
  assign bus.top = slots[top_ptr];
  assign bus.valid = (count != '0);

  // Pop on an empty stack is ignored
  assign do_pop = bus.pop & bus.valid;

  always_ff @(posedge clock) begin
    if (!reset) begin
      wptr <= '0;
      count <= '0;
      for (int i = 0; i < ras_entries; i++) begin
        slots[i] <= '0;
      end
    end else if (bus.push && do_pop) begin
      // Replace the top in place and keep the depth
      slots[top_ptr] <= bus.push_addr;
    end else if (bus.push) begin
      slots[wptr] <= bus.push_addr; // Overwrites the oldest when full
      wptr <= wptr + 1'b1;
      if (count != ras_count_t'(ras_entries)) begin
        count <= count + 1'b1;
      end
    end else if (do_pop) begin
      wptr <= top_ptr;
      count <= count - 1'b1;
    end
  end

endmodule
